/* src/laser_pkg.sv */
`default_nettype none

package laser_pkg;

	// Bus and memory widths
	typedef logic [15:0] addr_t;
	typedef logic [7:0]  data_t;
	typedef logic [13:0] ram_addr_t;
	typedef logic [10:0] vram_addr_t;
	typedef logic [5:0]  key_cols_t;
	typedef logic [7:0]  scancode_t;

	// Decoded bus target
	typedef enum logic [1:0]
	{
		REGION_NONE = 2'd0,
		REGION_IO   = 2'd1,
		REGION_VRAM = 2'd2,
		REGION_RAM  = 2'd3
	} region_t;

	typedef logic [3:0] phase_t;	// Numbered sequencer phases

	// CLK50MHZ cycles per CPU clock
	localparam int PHASES_NORMAL = 14;
	localparam int PHASES_TURBO  = 4;

	// Pages on A15-A11
	localparam logic [4:0] IO_PAGE   = 5'b01101;	// 6800-6FFF
	localparam logic [4:0] VRAM_PAGE = 5'b01110;	// 7000-77FF

	localparam addr_t RAM_BASE   = 16'h7800;
	localparam addr_t RAM_LAST   = 16'hB7FF;
	localparam int    RAM_WORDS  = 16384;
	localparam int    VRAM_WORDS = 2048;

	localparam data_t OPEN_BUS = 8'hFF;

	// Output latch bits at 6800
	localparam int IO_SPEAKER_A_BIT = 0;
	localparam int IO_SPEAKER_B_BIT = 5;
	localparam int IO_CASS_OUT_BIT  = 2;
	localparam int IO_AG_BIT        = 3;
	localparam int IO_CSS_BIT       = 4;

	localparam int KEY_ROWS = 8;	// Rows selected by A0-A7

endpackage

`default_nettype wire

/* src/cpu_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface cpu_bus_if;
	import laser_pkg::*;

	// Z80 side, active high
	addr_t addr;
	data_t wdata;
	logic  mreq;
	logic  iorq;
	logic  rd;
	logic  wr;

	region_t region;	// Valid only while mreq
	logic    wr_stb;
	logic    latch_stb;

	// Read data back to the mux
	data_t     ram_q;
	data_t     vram_q;
	data_t     io_q;
	key_cols_t key_cols;

	modport ctrl (input addr, mreq, rd, ram_q, vram_q, io_q,
		output region, wr_stb, latch_stb);

	// Each memory drives only its own read port
	modport mem (input addr, wdata, mreq, iorq, wr, region, wr_stb,
		output ram_q, vram_q);

	modport io (input wdata, mreq, wr, region, latch_stb, key_cols,
		output io_q);

	modport kbd (input addr, output key_cols);

endinterface

`default_nettype wire

/* src/bus_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_controller (
	input  logic             CLK50MHZ,
	input  logic             RESET_N,
	input  logic             turbo_i,
	cpu_bus_if.ctrl          bus,
	output logic             cpu_clk_o,
	output laser_pkg::data_t cpu_di_o
);
	import laser_pkg::*;

	phase_t phase;
	phase_t phase_last;
	logic   turbo_q;	// Speed of the running CPU clock period
	logic   strobe_phase;

	assign phase_last = turbo_q ? phase_t'(PHASES_TURBO - 1) : phase_t'(PHASES_NORMAL - 1);

	// CPU clock rises on the edge that leaves phase 0
	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			phase     <= '0;
			turbo_q   <= 1'b0;
			cpu_clk_o <= 1'b0;
		end
		else
		begin
			cpu_clk_o <= (phase == '0);
			if (phase == phase_last)
			begin
				phase   <= '0;
				turbo_q <= turbo_i;	// Speed change only at a period boundary
			end
			else
				phase <= phase + 1'b1;
		end
	end

	// Phase 1 is the cycle with cpu_clk_o high
	assign strobe_phase  = (phase == phase_t'(1));
	assign bus.wr_stb    = strobe_phase;
	assign bus.latch_stb = strobe_phase;

	// Address decode, nothing selected outside a memory request
	always_comb
	begin
		bus.region = REGION_NONE;
		if (bus.mreq)
		begin
			if (bus.addr[15:11] == IO_PAGE)
				bus.region = REGION_IO;
			else if (bus.addr[15:11] == VRAM_PAGE)
				bus.region = REGION_VRAM;
			else if (bus.addr >= RAM_BASE && bus.addr <= RAM_LAST)
				bus.region = REGION_RAM;	// 7800-7FFF folded into the 16K
		end
	end

	// Read mux toward the CPU data input
	always_comb
	begin
		if (!bus.rd)
			cpu_di_o = OPEN_BUS;
		else
		begin
			case (bus.region)
				REGION_IO:   cpu_di_o = bus.io_q;
				REGION_VRAM: cpu_di_o = bus.vram_q;
				REGION_RAM:  cpu_di_o = bus.ram_q;
				default:     cpu_di_o = OPEN_BUS;	// Undecoded, no floating bus
			endcase
		end
	end

	a_phase_range: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		phase <= phase_t'(PHASES_NORMAL - 1));

	// Memories and the I/O latch rely on this alignment
	a_wr_stb_in_clk: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		bus.wr_stb |-> cpu_clk_o);

endmodule

`default_nettype wire

/* src/main_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module main_ram (
	input logic    CLK50MHZ,
	cpu_bus_if.mem bus
);
	import laser_pkg::*;

	data_t     mem [RAM_WORDS];
	ram_addr_t word_addr;
	logic      we;

	assign word_addr = ram_addr_t'(bus.addr - RAM_BASE);	// 7800 maps to word 0

	// Memory write, never an I/O cycle
	assign we = bus.wr_stb && (bus.region == REGION_RAM) && bus.mreq && bus.wr && !bus.iorq;

	always_ff @(posedge CLK50MHZ)
	begin
		if (we)
			mem[word_addr] <= bus.wdata;
		bus.ram_q <= mem[word_addr];	// Registered read, one cycle behind addr
	end

	// Address comes from the external CPU
	a_wr_addr_known: assert property (@(posedge CLK50MHZ)
		we |-> !$isunknown(bus.addr));

endmodule

`default_nettype wire

/* src/video_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module video_ram (
	input  logic                  CLK50MHZ,
	cpu_bus_if.mem                bus,
	input  laser_pkg::vram_addr_t vdg_addr_i,
	output laser_pkg::data_t      vdg_data_o
);
	import laser_pkg::*;

	data_t      mem [VRAM_WORDS];
	vram_addr_t cpu_addr;
	logic       we;

	assign cpu_addr = bus.addr[10:0];

	assign we = bus.wr_stb && (bus.region == REGION_VRAM) && bus.mreq && bus.wr && !bus.iorq;

	// CPU port
	always_ff @(posedge CLK50MHZ)
	begin
		if (we)
			mem[cpu_addr] <= bus.wdata;
		bus.vram_q <= mem[cpu_addr];
	end

	// Video port for the display generator, read only
	always_ff @(posedge CLK50MHZ)
	begin
		vdg_data_o <= mem[vdg_addr_i];
	end

endmodule

`default_nettype wire

/* src/io_port.sv */
`timescale 1ns/1ps
`default_nettype none

module io_port (
	input  logic       CLK50MHZ,
	input  logic       RESET_N,
	cpu_bus_if.io      bus,
	input  logic       cass_in_i,
	output logic [1:0] speaker_o,
	output logic       cass_out_o,
	output logic       vdg_ag_o,
	output logic       vdg_css_o
);
	import laser_pkg::*;

	logic latch_we;

	// Any address in the 6800 page hits the latch
	assign latch_we = bus.latch_stb && (bus.region == REGION_IO) && bus.mreq && bus.wr;

	// Output latch, only the bits with a function are kept
	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			speaker_o  <= 2'b00;
			cass_out_o <= 1'b0;
			vdg_ag_o   <= 1'b0;
			vdg_css_o  <= 1'b0;
		end
		else if (latch_we)
		begin
			// Speaker pair, A on bit 1 and B on bit 0
			speaker_o  <= {bus.wdata[IO_SPEAKER_A_BIT], bus.wdata[IO_SPEAKER_B_BIT]};
			cass_out_o <= bus.wdata[IO_CASS_OUT_BIT];
			vdg_ag_o   <= bus.wdata[IO_AG_BIT];	// Graphics mode
			vdg_css_o  <= bus.wdata[IO_CSS_BIT];	// Colour set
		end
	end

	// Keyboard and cassette byte, sampled on every CPU clock pulse
	always_ff @(posedge CLK50MHZ)
	begin
		if (bus.latch_stb)
			bus.io_q <= {1'b1, ~cass_in_i, bus.key_cols};
	end

endmodule

`default_nettype wire

/* src/keyboard_matrix.sv */
`timescale 1ns/1ps
`default_nettype none

module keyboard_matrix (
	input  logic                 CLK50MHZ,
	input  logic                 RESET_N,
	input  logic                 key_strobe_i,
	input  logic                 key_pressed_i,
	input  laser_pkg::scancode_t key_code_i,
	cpu_bus_if.kbd               bus
);
	import laser_pkg::*;

	// Returns {valid, row, column}
	function automatic logic [6:0] key_map(input scancode_t code);
		case (code)
			// Row 0, A0 low
			8'h2C: key_map = {1'b1, 3'd0, 3'd0};	// T
			8'h1D: key_map = {1'b1, 3'd0, 3'd1};	// W
			8'h24: key_map = {1'b1, 3'd0, 3'd3};	// E
			8'h15: key_map = {1'b1, 3'd0, 3'd4};	// Q
			8'h2D: key_map = {1'b1, 3'd0, 3'd5};	// R
			// Row 1
			8'h34: key_map = {1'b1, 3'd1, 3'd0};	// G
			8'h1B: key_map = {1'b1, 3'd1, 3'd1};	// S
			8'h14: key_map = {1'b1, 3'd1, 3'd2};	// Ctrl
			8'h23: key_map = {1'b1, 3'd1, 3'd3};	// D
			8'h1C: key_map = {1'b1, 3'd1, 3'd4};	// A
			8'h2B: key_map = {1'b1, 3'd1, 3'd5};	// F
			// Row 2
			8'h32: key_map = {1'b1, 3'd2, 3'd0};	// B
			8'h22: key_map = {1'b1, 3'd2, 3'd1};	// X
			8'h12: key_map = {1'b1, 3'd2, 3'd2};	// Left shift
			8'h21: key_map = {1'b1, 3'd2, 3'd3};	// C
			8'h1A: key_map = {1'b1, 3'd2, 3'd4};	// Z
			8'h2A: key_map = {1'b1, 3'd2, 3'd5};	// V
			// Row 3, column 2 has no key
			8'h2E: key_map = {1'b1, 3'd3, 3'd0};	// 5
			8'h1E: key_map = {1'b1, 3'd3, 3'd1};	// 2
			8'h26: key_map = {1'b1, 3'd3, 3'd3};	// 3
			8'h16: key_map = {1'b1, 3'd3, 3'd4};	// 1
			8'h25: key_map = {1'b1, 3'd3, 3'd5};	// 4
			// Row 4
			8'h31: key_map = {1'b1, 3'd4, 3'd0};	// N
			8'h49: key_map = {1'b1, 3'd4, 3'd1};	// .
			8'h41: key_map = {1'b1, 3'd4, 3'd3};	// ,
			8'h29: key_map = {1'b1, 3'd4, 3'd4};	// Space
			8'h3A: key_map = {1'b1, 3'd4, 3'd5};	// M
			// Row 5
			8'h36: key_map = {1'b1, 3'd5, 3'd0};	// 6
			8'h46: key_map = {1'b1, 3'd5, 3'd1};	// 9
			8'h4E: key_map = {1'b1, 3'd5, 3'd2};	// -
			8'h3E: key_map = {1'b1, 3'd5, 3'd3};	// 8
			8'h45: key_map = {1'b1, 3'd5, 3'd4};	// 0
			8'h3D: key_map = {1'b1, 3'd5, 3'd5};	// 7
			// Row 6
			8'h35: key_map = {1'b1, 3'd6, 3'd0};	// Y
			8'h44: key_map = {1'b1, 3'd6, 3'd1};	// O
			8'h5A: key_map = {1'b1, 3'd6, 3'd2};	// Return
			8'h43: key_map = {1'b1, 3'd6, 3'd3};	// I
			8'h4D: key_map = {1'b1, 3'd6, 3'd4};	// P
			8'h3C: key_map = {1'b1, 3'd6, 3'd5};	// U
			// Row 7
			8'h33: key_map = {1'b1, 3'd7, 3'd0};	// H
			8'h4B: key_map = {1'b1, 3'd7, 3'd1};	// L
			8'h52: key_map = {1'b1, 3'd7, 3'd2};	// Quote key gives colon
			8'h42: key_map = {1'b1, 3'd7, 3'd3};	// K
			8'h4C: key_map = {1'b1, 3'd7, 3'd4};	// ;
			8'h3B: key_map = {1'b1, 3'd7, 3'd5};	// J
			default: key_map = '0;
		endcase
	endfunction

	logic [6:0] hit;
	key_cols_t  key_down [KEY_ROWS];	// 1 while held

	assign hit = key_map(key_code_i);

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			for (int r = 0; r < KEY_ROWS; r++)
				key_down[r] <= '0;
		end
		else if (key_strobe_i && hit[6])
			key_down[hit[5:3]][hit[2:0]] <= key_pressed_i;
	end

	// Row scan, a pressed key in any selected row pulls its column low
	always_comb
	begin
		bus.key_cols = '1;
		for (int r = 0; r < KEY_ROWS; r++)
		begin
			if (!bus.addr[r])
				bus.key_cols = bus.key_cols & ~key_down[r];
		end
	end

endmodule

`default_nettype wire

/* src/laser310_top.sv */
`timescale 1ns/1ps
`default_nettype none

module laser310_top (
	input  logic                  CLK50MHZ,
	input  logic                  RESET_N,
	input  logic                  turbo_i,
	input  laser_pkg::addr_t      cpu_addr_i,
	input  laser_pkg::data_t      cpu_data_i,
	input  logic                  cpu_mreq_i,
	input  logic                  cpu_iorq_i,
	input  logic                  cpu_rd_i,
	input  logic                  cpu_wr_i,
	output logic                  cpu_clk_o,
	output laser_pkg::data_t      cpu_di_o,
	input  logic                  key_strobe_i,
	input  logic                  key_pressed_i,
	input  laser_pkg::scancode_t  key_code_i,
	input  logic                  cass_in_i,
	input  laser_pkg::vram_addr_t vdg_addr_i,
	output laser_pkg::data_t      vdg_data_o,
	output logic [1:0]            speaker_o,
	output logic                  cass_out_o,
	output logic                  vdg_ag_o,
	output logic                  vdg_css_o
);

	cpu_bus_if bus ();

	// External Z80 bus onto the shared interface
	assign bus.addr  = cpu_addr_i;
	assign bus.wdata = cpu_data_i;
	assign bus.mreq  = cpu_mreq_i;
	assign bus.iorq  = cpu_iorq_i;
	assign bus.rd    = cpu_rd_i;
	assign bus.wr    = cpu_wr_i;

	bus_controller ctrl0 (
		.CLK50MHZ  (CLK50MHZ),
		.RESET_N   (RESET_N),
		.turbo_i   (turbo_i),
		.bus       (bus.ctrl),
		.cpu_clk_o (cpu_clk_o),
		.cpu_di_o  (cpu_di_o)
	);

	main_ram ram0 (
		.CLK50MHZ (CLK50MHZ),
		.bus      (bus.mem)
	);

	video_ram vram0 (
		.CLK50MHZ   (CLK50MHZ),
		.bus        (bus.mem),
		.vdg_addr_i (vdg_addr_i),
		.vdg_data_o (vdg_data_o)
	);

	io_port io0 (
		.CLK50MHZ   (CLK50MHZ),
		.RESET_N    (RESET_N),
		.bus        (bus.io),
		.cass_in_i  (cass_in_i),
		.speaker_o  (speaker_o),
		.cass_out_o (cass_out_o),
		.vdg_ag_o   (vdg_ag_o),
		.vdg_css_o  (vdg_css_o)
	);

	keyboard_matrix kbd0 (
		.CLK50MHZ      (CLK50MHZ),
		.RESET_N       (RESET_N),
		.key_strobe_i  (key_strobe_i),
		.key_pressed_i (key_pressed_i),
		.key_code_i    (key_code_i),
		.bus           (bus.kbd)
	);

endmodule

`default_nettype wire

/* tb/tb_laser310.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_laser310;
	import laser_pkg::*;

	localparam int WAIT_LIMIT = 40;	// Longer than any CPU clock period

	// PS/2 set 2 codes
	localparam scancode_t CODE_T     = 8'h2C;	// Row 0 column 0
	localparam scancode_t CODE_A     = 8'h1C;	// Row 1 column 4
	localparam scancode_t CODE_SPACE = 8'h29;	// Row 4 column 4

	logic       CLK50MHZ;
	logic       RESET_N;
	logic       turbo_i;
	addr_t      cpu_addr_i;
	data_t      cpu_data_i;
	logic       cpu_mreq_i;
	logic       cpu_iorq_i;
	logic       cpu_rd_i;
	logic       cpu_wr_i;
	logic       cpu_clk_o;
	data_t      cpu_di_o;
	logic       key_strobe_i;
	logic       key_pressed_i;
	scancode_t  key_code_i;
	logic       cass_in_i;
	vram_addr_t vdg_addr_i;
	data_t      vdg_data_o;
	logic [1:0] speaker_o;
	logic       cass_out_o;
	logic       vdg_ag_o;
	logic       vdg_css_o;

	data_t ram_model [int unsigned];	// Expected main RAM contents
	addr_t ram_written [$];

	laser310_top dut0 (
		.CLK50MHZ      (CLK50MHZ),
		.RESET_N       (RESET_N),
		.turbo_i       (turbo_i),
		.cpu_addr_i    (cpu_addr_i),
		.cpu_data_i    (cpu_data_i),
		.cpu_mreq_i    (cpu_mreq_i),
		.cpu_iorq_i    (cpu_iorq_i),
		.cpu_rd_i      (cpu_rd_i),
		.cpu_wr_i      (cpu_wr_i),
		.cpu_clk_o     (cpu_clk_o),
		.cpu_di_o      (cpu_di_o),
		.key_strobe_i  (key_strobe_i),
		.key_pressed_i (key_pressed_i),
		.key_code_i    (key_code_i),
		.cass_in_i     (cass_in_i),
		.vdg_addr_i    (vdg_addr_i),
		.vdg_data_o    (vdg_data_o),
		.speaker_o     (speaker_o),
		.cass_out_o    (cass_out_o),
		.vdg_ag_o      (vdg_ag_o),
		.vdg_css_o     (vdg_css_o)
	);

	initial
	begin
		CLK50MHZ = 1'b0;
		forever
			#10 CLK50MHZ = ~CLK50MHZ;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp)
		else
		begin
			$display("error: %s is %h, expected %h", name, got, exp);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic next_cycle();
		@(posedge CLK50MHZ);
		#1;
	endtask

	task automatic wait_cpu_clk(input logic level);
		int n;
		n = 0;
		while (cpu_clk_o !== level)
		begin
			next_cycle();
			n++;
			if (n > WAIT_LIMIT)
				stop_run($sformatf("Timeout, cpu_clk_o never went to %0d", level));
		end
	endtask

	// Cycles from one CPU clock pulse to the next
	task automatic measure_period(output int cycles);
		int n;
		wait_cpu_clk(1'b1);
		n = 1;
		next_cycle();
		while (cpu_clk_o !== 1'b1)
		begin
			next_cycle();
			n++;
			if (n > WAIT_LIMIT)
				stop_run("Timeout, no second cpu_clk_o pulse");
		end
		cycles = n;
	endtask

	// One memory request held over two CPU clock pulses
	task automatic bus_cycle(input addr_t addr, input data_t wdata, input logic wr,
		input logic iorq, output data_t rdata);
		wait_cpu_clk(1'b0);
		cpu_addr_i = addr;
		cpu_data_i = wdata;
		cpu_mreq_i = 1'b1;
		cpu_iorq_i = iorq;
		cpu_rd_i   = !wr;
		cpu_wr_i   = wr;
		wait_cpu_clk(1'b1);
		next_cycle();
		wait_cpu_clk(1'b1);
		@(negedge CLK50MHZ);
		rdata = cpu_di_o;	// Mid second pulse
		next_cycle();
		cpu_mreq_i = 1'b0;
		cpu_iorq_i = 1'b0;
		cpu_rd_i   = 1'b0;
		cpu_wr_i   = 1'b0;
	endtask

	task automatic write_byte(input addr_t addr, input data_t wdata);
		data_t unused_q;
		bus_cycle(addr, wdata, 1'b1, 1'b0, unused_q);
	endtask

	task automatic expect_read(input addr_t addr, input data_t exp);
		data_t q;
		bus_cycle(addr, 8'h00, 1'b0, 1'b0, q);
		check_value($sformatf("cpu_di_o at %h", addr), 16'(q), 16'(exp));
	endtask

	task automatic send_key(input scancode_t code, input logic pressed);
		key_code_i    = code;
		key_pressed_i = pressed;
		key_strobe_i  = 1'b1;
		next_cycle();
		key_strobe_i  = 1'b0;
	endtask

	// Latch bits 0 and 5 speaker, 2 cassette, 3 AG, 4 CSS
	task automatic check_latch(input data_t d);
		check_value("speaker_o", 16'(speaker_o), 16'({d[0], d[5]}));
		check_value("cass_out_o", 16'(cass_out_o), 16'(d[2]));
		check_value("vdg_ag_o", 16'(vdg_ag_o), 16'(d[3]));
		check_value("vdg_css_o", 16'(vdg_css_o), 16'(d[4]));
	endtask

	initial
	begin
		int          cycles;
		addr_t       a;
		data_t       d;
		data_t       q;
		data_t       io_d;
		void'($urandom(95));
		RESET_N       = 1'b0;
		turbo_i       = 1'b0;
		cpu_addr_i    = '0;
		cpu_data_i    = '0;
		cpu_mreq_i    = 1'b0;
		cpu_iorq_i    = 1'b0;
		cpu_rd_i      = 1'b0;
		cpu_wr_i      = 1'b0;
		key_strobe_i  = 1'b0;
		key_pressed_i = 1'b0;
		key_code_i    = '0;
		cass_in_i     = 1'b0;
		vdg_addr_i    = '0;
		repeat (5) @(posedge CLK50MHZ);
		#1 RESET_N = 1'b1;
		check_value("cpu_clk_o", 16'(cpu_clk_o), 16'h0);
		check_latch(8'h00);

		// First period after a speed change still runs at the old rate
		measure_period(cycles);
		check_value("cpu_clk_o period", 16'(cycles), 16'd14);
		turbo_i = 1'b1;
		measure_period(cycles);
		measure_period(cycles);
		check_value("cpu_clk_o turbo period", 16'(cycles), 16'd4);
		turbo_i = 1'b0;
		measure_period(cycles);
		measure_period(cycles);
		check_value("cpu_clk_o period", 16'(cycles), 16'd14);

		// Main RAM at 7800-B7FF
		repeat (20)
		begin
			a = addr_t'(32'h7800 + ($urandom % 32'd16384));
			d = data_t'($urandom);
			write_byte(a, d);
			ram_model[a] = d;
			ram_written.push_back(a);
		end
		repeat (6)
		begin
			a = ram_written[$urandom % ram_written.size()];
			bus_cycle(a, ~ram_model[a], 1'b1, 1'b1, q);	// I/O cycle leaves memory alone
		end
		foreach (ram_model[i])
			expect_read(addr_t'(i), ram_model[i]);

		// Video RAM through the CPU port and then the video port
		repeat (4)
		begin
			a = addr_t'(32'h7000 + ($urandom % 32'd2048));
			d = data_t'($urandom);
			write_byte(a, d);
			expect_read(a, d);
			vdg_addr_i = vram_addr_t'(a);
			next_cycle();
			check_value("vdg_data_o", 16'(vdg_data_o), 16'(d));
		end

		// Output latch anywhere in 6800-6FFF
		repeat (4)
		begin
			a    = addr_t'(32'h6800 + ($urandom % 32'd2048));
			io_d = data_t'($urandom);
			write_byte(a, io_d);
			check_latch(io_d);
		end
		write_byte(16'h9000, ~io_d);
		check_latch(io_d);

		// Keyboard rows selected by A0-A7
		send_key(CODE_T, 1'b1);
		expect_read(16'h68FE, 8'hFE);
		expect_read(16'h68FD, 8'hFF);
		send_key(CODE_T, 1'b0);
		send_key(CODE_A, 1'b1);
		expect_read(16'h68FD, 8'hEF);
		expect_read(16'h68FE, 8'hFF);
		send_key(CODE_SPACE, 1'b1);
		expect_read(16'h68EF, 8'hEF);
		cass_in_i = 1'b1;	// Bit 6 reads the inverted cassette input
		expect_read(16'h68FD, 8'hAF);
		expect_read(16'h68FE, 8'hBF);
		expect_read(16'h68EF, 8'hAF);

		// Undecoded space reads as open bus
		expect_read(16'h0000, 8'hFF);
		expect_read(16'h67FF, 8'hFF);
		expect_read(16'hB800, 8'hFF);
		expect_read(16'hFFFF, 8'hFF);
		repeat (6)
		begin
			expect_read(addr_t'($urandom % 32'h6800), 8'hFF);
			expect_read(addr_t'(32'hB800 + ($urandom % 32'h4800)), 8'hFF);
		end

		$display("No errors");
		$finish;
	end

	// CPU clock is a single CLK50MHZ cycle wide
	a_clk_pulse_width: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		cpu_clk_o |=> !cpu_clk_o)
	else
	begin
		$display("cpu_clk_o stayed high for more than one cycle");
		$display("Errors found");
		$fatal(1);
	end

endmodule

`default_nettype wire

/* vlog.f */
src/laser_pkg.sv
src/cpu_bus_if.sv
src/bus_controller.sv
src/main_ram.sv
src/video_ram.sv
src/io_port.sv
src/keyboard_matrix.sv
src/laser310_top.sv
tb/tb_laser310.sv

/* Makefile */
VERILATOR  = verilator
VFLAGS     = --timing --assert
TOP        = tb_laser310
FILELIST   = vlog.f
OBJ_DIR    = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
